/* tb.f */
rtl/lsuPkg.sv
rtl/lsuDecoder.sv
rtl/lsuControl.sv
rtl/clearCounter.sv
rtl/blockMemory.sv
rtl/loadFormatter.sv
rtl/storeMerger.sv
rtl/loadStoreUnit.sv
test/loadStoreUnit_sva.sv
test/loadStoreUnitTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module loadStoreUnitTb -f tb.f -o simv
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation passed" sim.log; then
	echo "run.sh: PASS"
else
	echo "run.sh: FAIL"
	exit 1
fi

/* test/loadStoreUnitTb.sv */
`timescale 1ns/1ps
`default_nettype none

module loadStoreUnitTb;

	localparam int numBlocks = 16;
	localparam logic [63:0] memBytes = 64'(numBlocks * 16); // first address past memory

	typedef struct packed {
		logic [31:0] due; // cycle the result shows up
		logic fault;
		lsuPkg::wbPort_t wb1;
		lsuPkg::wbPort_t wb2;
	} expectation_t;

	logic clock;
	logic reset;
	logic enable;
	logic [1:0] unitCode;
	logic [5:0] opCode;
	logic [4:0] format;
	logic [63:0] operand1; // rs for stores
	logic [63:0] operand2; // ra base
	logic [4:0] reg1Address;
	logic [4:0] reg2Address;
	logic [15:0] immediate;
	wire stall;
	wire fault;
	wire lsuPkg::wbPort_t reg1Wb;
	wire lsuPkg::wbPort_t reg2Wb;

	integer seed;
	logic [31:0] cycle = '0; // advanced at each falling edge
	logic [7:0] refMem [numBlocks * 16]; // byte model, big-endian
	expectation_t expQ [$]; // in due order

	loadStoreUnit #(.numBlocks(numBlocks)) DUT (
		.clock_i(clock), .reset_i(reset), .enable_i(enable), .functionalUnitCode_i(unitCode),
		.opCode_i(opCode), .instructionFormat_i(format), .operand1_i(operand1),
		.operand2_i(operand2), .reg1Address_i(reg1Address), .reg2Address_i(reg2Address),
		.imm_i(immediate), .stall_o(stall), .fault_o(fault), .reg1Wb_o(reg1Wb),
		.reg2Wb_o(reg2Wb)
	);

	always #2 clock = ~clock; // 4 ns period

	//////////////////////////////////////////////////
	// reference model

	function automatic int accessBytes(input logic [5:0] op);
		case (op)
			6'd34, 6'd35, 6'd38, 6'd39: return 1; // lbz, stb
			6'd40, 6'd41, 6'd42, 6'd43, 6'd44, 6'd45: return 2; // lhz, lha, sth
			6'd32, 6'd33, 6'd36, 6'd37: return 4; // lwz, stw
			default: return 0; // not supported here
		endcase
	endfunction

	function automatic logic isStoreOp(input logic [5:0] op);
		return (op >= 6'd36 && op <= 6'd39) || op == 6'd44 || op == 6'd45;
	endfunction

	function automatic expectation_t expectedLoad(input logic [5:0] op, input logic [63:0] ea,
		input logic [4:0] rt, input logic [4:0] ra);
		expectation_t e;
		int n;
		logic [63:0] val;
		e = '0;
		val = '0;
		n = accessBytes(op);
		if (n == 0 || (ea[1:0] & 2'(n - 1)) != 2'b00 || ea >= memBytes) begin
			e.fault = 1'b1; // strobe only
			return e;
		end
		for (int i = 0; i < n; i++)
			val = {val[55:0], refMem[ea[7:0] + 8'(i)]}; // first byte most significant
		if (op == 6'd42 || op == 6'd43)
			val = {{48{val[15]}}, val[15:0]}; // lha, lhau
		e.wb1.en = !isStoreOp(op);
		e.wb1.addr = rt;
		e.wb1.value = val;
		e.wb2.en = op[0]; // odd opcodes update ra
		e.wb2.addr = ra;
		e.wb2.value = ea;
		return e;
	endfunction

	task automatic writeModel(input logic [5:0] op, input logic [63:0] ea, input logic [63:0] rs);
		int n;
		n = accessBytes(op);
		for (int i = 0; i < n; i++)
			refMem[ea[7:0] + 8'(i)] = rs[8 * (n - 1 - i) +: 8]; // low bytes of rs
	endtask

	function automatic logic [63:0] randomWord();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = $random(seed);
		lo = $random(seed);
		return {hi, lo};
	endfunction

	//////////////////////////////////////////////////
	// checks

	task automatic abortRun();
		$display("Simulation failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic checkWb(input string name, input lsuPkg::wbPort_t got,
		input lsuPkg::wbPort_t exp);
		if (got.en !== exp.en || (exp.en && (got.addr !== exp.addr || got.value !== exp.value)))
		begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
			abortRun();
		end
	endtask

	task automatic checkFault(input logic got, input logic exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: fault_o got %b expected %b", $time, got, exp);
			abortRun();
		end
	endtask

	// outputs settle well before the falling edge
	always @(negedge clock) begin : compare
		expectation_t e;
		e = '0; // idle cycle, all strobes low
		if (expQ.size() != 0 && expQ[0].due == cycle)
			e = expQ.pop_front();
		if (!reset) begin
			checkFault(fault, e.fault);
			checkWb("reg1Wb_o", reg1Wb, e.wb1);
			checkWb("reg2Wb_o", reg2Wb, e.wb2);
		end
		cycle = cycle + 1;
	end

	//////////////////////////////////////////////////
	// stimulus

	task automatic issue(input logic [5:0] op, input logic [63:0] ea, input logic [63:0] rs);
		expectation_t e;
		logic [63:0] r;
		r = randomWord();
		@(posedge clock);
		enable <= 1'b1;
		opCode <= op;
		operand1 <= rs;
		operand2 <= ea - {{48{r[15]}}, r[15:0]}; // random split of ea
		immediate <= r[15:0];
		reg1Address <= r[20:16];
		reg2Address <= r[25:21];
		e = expectedLoad(op, ea, r[20:16], r[25:21]);
		e.due = cycle + (e.fault ? 32'd1 : 32'd3);
		expQ.push_back(e);
		if (!e.fault && isStoreOp(op))
			writeModel(op, ea, rs);
	endtask

	task automatic settle(); // drop enable, wait for results and stall
		int waited;
		@(posedge clock);
		enable <= 1'b0;
		waited = 0;
		do begin
			@(negedge clock);
			#1;
			waited++;
			if (waited > 20) begin
				$display("DUT did not go idle within 20 cycles at %0t", $time);
				abortRun();
			end
		end while (stall || expQ.size() != 0);
	endtask

	initial begin : stimulus
		logic [63:0] r;
		logic [63:0] ea;
		logic [5:0] op;
		int stallCycles;
		clock = 1'b0;
		seed = 32'h20111680;
		reset <= 1'b1;
		enable <= 1'b0;
		unitCode <= lsuPkg::ldStUnitCode;
		format <= lsuPkg::formatD;
		opCode <= '0;
		operand1 <= '0;
		operand2 <= '0;
		reg1Address <= '0;
		reg2Address <= '0;
		immediate <= '0;
		for (int i = 0; i < numBlocks * 16; i++)
			refMem[i] = 8'h00; // memory is wiped after reset
		repeat (4) @(posedge clock);
		reset <= 1'b0;

		stallCycles = 0; // clearing walk
		@(negedge clock);
		while (stall) begin
			stallCycles++;
			if (stallCycles > 100) begin
				$display("stall_o never fell after reset at %0t", $time);
				abortRun();
			end
			@(negedge clock);
		end
		if (stallCycles != numBlocks) begin
			$display("CHECK FAILED at %0t: stall_o cycles got %0d expected %0d", $time,
				stallCycles, numBlocks);
			abortRun();
		end
		for (int b = 0; b < numBlocks; b++) begin
			r = randomWord();
			issue(6'd32, 64'(b * 16) | {60'd0, r[3:2], 2'b00}, r); // all zero
		end
		settle();

		repeat (12) begin // stores, then every load size at that spot
			r = randomWord();
			case (r[1:0])
				2'd0: op = 6'd38; // stb
				2'd1: op = 6'd44; // sth
				default: op = 6'd36; // stw
			endcase
			op[0] = r[2];
			ea = {56'd0, r[15:8]} & ~64'(accessBytes(op) - 1);
			issue(op, ea, randomWord());
			settle();
			issue({5'b10001, r[3]}, ea, r); // lbz
			issue({5'b10100, r[4]}, {ea[63:1], 1'b0}, r); // lhz
			issue({5'b10000, r[5]}, {ea[63:2], 2'b00}, r); // lwz, back to back
			settle();
		end

		for (int k = 0; k < 4; k++) begin // sign bit alternates
			r = randomWord();
			ea = {56'd0, r[23:17], 1'b0};
			issue(6'd44, ea, {r[63:16], k[0], r[14:0]});
			settle();
			issue({5'b10101, r[30]}, ea, r); // lha, lhau
			settle();
		end

		for (int k = 0; k < 8; k++) begin // mixed loads every cycle
			r = randomWord();
			case (r[1:0])
				2'd0: op = 6'd34;
				2'd1: op = 6'd40;
				2'd2: op = 6'd42;
				default: op = 6'd32;
			endcase
			op[0] = r[2];
			issue(op, {56'd0, r[15:8]} & ~64'(accessBytes(op) - 1), r);
		end
		settle();

		issue(6'd40, 64'd5, r); // lhz odd
		issue(6'd32, 64'd18, r); // lwz off by two
		issue(6'd44, 64'd33, r); // sth odd
		issue(6'd36, 64'd256, r); // block 16
		issue(6'd38, 64'hFFFF_FFFF_FFFF_FFF0, r); // far past memory
		issue(6'd46, 64'd0, r); // lmw
		issue(6'd47, 64'd16, r); // stmw
		issue(6'd50, 64'd32, r);
		settle();

		for (int w = 0; w < numBlocks * 4; w++)
			issue(6'd32, 64'(w * 4), r); // whole memory against the model
		settle();
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

/* test/loadStoreUnit_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module loadStoreUnit_sva (
	input wire clock_i,
	input wire reset_i,
	input wire clearing_i,
	input wire reqValid_i,
	input wire isStore_i,
	input wire stall_i,
	input wire fault_i,
	input wire lsuPkg::wbPort_t reg1Wb_i,
	input wire lsuPkg::wbPort_t reg2Wb_i
);

	wire storeStart = reqValid_i && isStore_i; // storeRead cycle

	clearQuiet: assert property (@(posedge clock_i) disable iff (reset_i)
		clearing_i |-> !reg1Wb_i.en && !reg2Wb_i.en)
		else $error("writeback while memory is cleared");

	faultAlone: assert property (@(posedge clock_i) disable iff (reset_i)
		!(fault_i && reg1Wb_i.en))
		else $error("fault together with a load result");

	// two stall cycles per store and then free again
	storeStall: assert property (@(posedge clock_i) disable iff (reset_i)
		storeStart |=> stall_i)
		else $error("stall missing during a store");

	storeRelease: assert property (@(posedge clock_i) disable iff (reset_i)
		$past(storeStart, 2) |-> !stall_i)
		else $error("stall longer than two cycles after a store");

endmodule

bind loadStoreUnit loadStoreUnit_sva rules (
	.clock_i, .reset_i, .clearing_i(useClearData), .reqValid_i(reqValid),
	.isStore_i(req.isStore), .stall_i(stall_o), .fault_i(fault_o),
	.reg1Wb_i(reg1Wb_o), .reg2Wb_i(reg2Wb_o)
);

`default_nettype wire

/* rtl/loadStoreUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module loadStoreUnit #(
	parameter int numBlocks = 128
) (
	input wire clock_i,
	input wire reset_i,
	input wire enable_i,
	input wire [1:0] functionalUnitCode_i,
	input wire [5:0] opCode_i,
	input wire [4:0] instructionFormat_i,
	input wire [63:0] operand1_i,
	input wire [63:0] operand2_i,
	input wire [4:0] reg1Address_i,
	input wire [4:0] reg2Address_i,
	input wire [15:0] imm_i,
	output wire stall_o,
	output wire fault_o,
	output wire lsuPkg::wbPort_t reg1Wb_o,
	output wire lsuPkg::wbPort_t reg2Wb_o
);

	wire lsuPkg::lsuReq_t req;
	wire reqValid;
	wire count, last, loadGo, storeDone;
	wire memReadEn, memWriteEn, useClearData;
	wire lsuPkg::blockIndex_t clearIndex, ctrlIndex, memIndex;
	wire [lsuPkg::blockBits-1:0] readData, merged, writeData;

	// clearing uses the counter index and zero data
	assign memIndex = useClearData ? clearIndex : ctrlIndex;
	assign writeData = useClearData ? '0 : merged;

	lsuDecoder #(.numBlocks(numBlocks)) decoder (
		.clock_i, .reset_i, .enable_i, .stall_i(stall_o), .functionalUnitCode_i,
		.opCode_i, .instructionFormat_i, .operand1_i, .operand2_i,
		.reg1Address_i, .reg2Address_i, .imm_i,
		.req_o(req), .reqValid_o(reqValid), .fault_o
	);

	lsuControl control (
		.clock_i, .reset_i, .reqValid_i(reqValid), .isStore_i(req.isStore),
		.blockIndex_i(req.blockIndex), .last_i(last), .stall_o, .count_o(count),
		.memReadEn_o(memReadEn), .memIndex_o(ctrlIndex), .memWriteEn_o(memWriteEn),
		.useClearData_o(useClearData), .loadGo_o(loadGo), .storeDone_o(storeDone)
	);

	clearCounter #(.numBlocks(numBlocks)) counter (
		.clock_i, .reset_i, .count_i(count), .index_o(clearIndex), .last_o(last)
	);

	blockMemory #(.numBlocks(numBlocks)) memory (
		.clock_i, .readEn_i(memReadEn), .writeEn_i(memWriteEn), .index_i(memIndex),
		.writeData_i(writeData), .readData_o(readData)
	);

	storeMerger merger (
		.block_i(readData), .storeVal_i(req.storeVal), .byteOffset_i(req.byteOffset),
		.size_i(req.size), .merged_o(merged)
	);

	loadFormatter formatter (
		.clock_i, .reset_i, .loadGo_i(loadGo), .storeDone_i(storeDone), .req_i(req),
		.block_i(readData), .reg1Wb_o, .reg2Wb_o
	);

endmodule

`default_nettype wire

/* rtl/storeMerger.sv */
`timescale 1ns/1ps
`default_nettype none

module storeMerger (
	input wire [lsuPkg::blockBits-1:0] block_i,
	input wire [63:0] storeVal_i,
	input wire [3:0] byteOffset_i,
	input wire lsuPkg::accessSize_t size_i,
	output logic [lsuPkg::blockBits-1:0] merged_o
);

	localparam int restBits = lsuPkg::blockBits - 32;

	logic [4:0] padBits; // unused low part of the word lane
	logic [31:0] laneWord; // store bytes left-aligned
	logic [31:0] laneMask;
	logic [lsuPkg::blockBits-1:0] data;
	logic [lsuPkg::blockBits-1:0] mask;

	always_comb begin
		case (size_i)
			lsuPkg::sizeByte: padBits = 5'd24;
			lsuPkg::sizeHalf: padBits = 5'd16;
			default: padBits = 5'd0;
		endcase
	end

	assign laneWord = storeVal_i[31:0] << padBits; // low bytes of rs
	assign laneMask = 32'hFFFF_FFFF << padBits;
	assign data = {laneWord, {restBits{1'b0}}} >> {byteOffset_i, 3'b000}; // big-endian place
	assign mask = {laneMask, {restBits{1'b0}}} >> {byteOffset_i, 3'b000};
	assign merged_o = (block_i & ~mask) | (data & mask);

endmodule

`default_nettype wire

/* rtl/loadFormatter.sv */
`timescale 1ns/1ps
`default_nettype none

module loadFormatter (
	input wire clock_i,
	input wire reset_i,
	input wire loadGo_i,
	input wire storeDone_i,
	input wire lsuPkg::lsuReq_t req_i,
	input wire [lsuPkg::blockBits-1:0] block_i,
	output lsuPkg::wbPort_t reg1Wb_o,
	output lsuPkg::wbPort_t reg2Wb_o
);

	localparam int top = lsuPkg::blockBits - 1;

	lsuPkg::lsuReq_t reqDly; // request lined up with read data
	logic [lsuPkg::blockBits-1:0] shifted; // addressed byte moved to the top
	logic signBit;
	logic [63:0] loadVal;

	assign shifted = block_i << {reqDly.byteOffset, 3'b000};
	assign signBit = reqDly.isAlgebraic & shifted[top];

	always_comb begin
		case (reqDly.size)
			lsuPkg::sizeByte: loadVal = {{56{signBit}}, shifted[top -: 8]};
			lsuPkg::sizeHalf: loadVal = {{48{signBit}}, shifted[top -: 16]};
			default: loadVal = {{32{signBit}}, shifted[top -: 32]};
		endcase
	end

	always_ff @(posedge clock_i) begin
		reqDly <= req_i; // one cycle of read latency
		reg1Wb_o.addr <= reqDly.rtAddr;
		reg1Wb_o.value <= loadVal;
		reg2Wb_o.addr <= reqDly.raAddr;
		reg2Wb_o.value <= reqDly.effAddr; // update forms write back the EA
		if (reset_i) begin
			reg1Wb_o.en <= 1'b0;
			reg2Wb_o.en <= 1'b0;
		end else begin
			reg1Wb_o.en <= loadGo_i;
			reg2Wb_o.en <= (loadGo_i || storeDone_i) && reqDly.isUpdate;
		end
	end

endmodule

`default_nettype wire

/* rtl/blockMemory.sv */
`timescale 1ns/1ps
`default_nettype none

module blockMemory #(
	parameter int numBlocks = 128
) (
	input wire clock_i,
	input wire readEn_i,
	input wire writeEn_i,
	input wire lsuPkg::blockIndex_t index_i,
	input wire [lsuPkg::blockBits-1:0] writeData_i,
	output logic [lsuPkg::blockBits-1:0] readData_o
);

	localparam int addrBits = (numBlocks > 1) ? $clog2(numBlocks) : 1;

	logic [lsuPkg::blockBits-1:0] mem [numBlocks]; // cleared by the walk after reset
	wire [addrBits-1:0] addr = index_i[addrBits-1:0]; // decoder keeps index in range

	always_ff @(posedge clock_i) begin
		if (writeEn_i)
			mem[addr] <= writeData_i;
		if (readEn_i)
			readData_o <= mem[addr]; // held when not reading
	end

endmodule

`default_nettype wire

/* rtl/clearCounter.sv */
`timescale 1ns/1ps
`default_nettype none

module clearCounter #(
	parameter int numBlocks = 128
) (
	input wire clock_i,
	input wire reset_i,
	input wire count_i,
	output lsuPkg::blockIndex_t index_o,
	output logic last_o
);

	assign last_o = index_o == lsuPkg::blockIndex_t'(numBlocks - 1); // final block

	always_ff @(posedge clock_i) begin
		if (reset_i)
			index_o <= '0;
		else if (count_i)
			index_o <= last_o ? '0 : index_o + 1'b1; // wrap after last
	end

endmodule

`default_nettype wire

/* rtl/lsuControl.sv */
`timescale 1ns/1ps
`default_nettype none

module lsuControl (
	input wire clock_i,
	input wire reset_i,
	input wire reqValid_i,
	input wire isStore_i,
	input wire lsuPkg::blockIndex_t blockIndex_i,
	input wire last_i,
	output logic stall_o,
	output logic count_o,
	output logic memReadEn_o,
	output lsuPkg::blockIndex_t memIndex_o,
	output logic memWriteEn_o,
	output logic useClearData_o,
	output logic loadGo_o,
	output logic storeDone_o
);

	lsuPkg::lsuState_t stateReg; // clearing, ready or storeWrite
	lsuPkg::lsuState_t state; // current state incl. storeRead
	lsuPkg::blockIndex_t storeIndex; // block under read-modify-write

	// a store arriving in ready is the storeRead cycle, its read goes out now
	assign state = (stateReg == lsuPkg::ready && reqValid_i && isStore_i) ?
		lsuPkg::storeRead : stateReg;

	//////////////////////////////////////////////////
	// state register

	always_ff @(posedge clock_i) begin
		if (reset_i)
			stateReg <= lsuPkg::clearing; // wipe memory first
		else begin
			case (state)
				lsuPkg::clearing: if (last_i) stateReg <= lsuPkg::ready;
				lsuPkg::storeRead: stateReg <= lsuPkg::storeWrite;
				lsuPkg::storeWrite: stateReg <= lsuPkg::ready;
				default: stateReg <= stateReg; // stay ready
			endcase
		end
	end

	always_ff @(posedge clock_i) begin
		if (state == lsuPkg::storeRead)
			storeIndex <= blockIndex_i;
		if (reset_i)
			loadGo_o <= 1'b0;
		else
			loadGo_o <= reqValid_i && !isStore_i; // data arrives next cycle
	end

	//////////////////////////////////////////////////
	// outputs

	assign stall_o = state != lsuPkg::ready;
	assign count_o = state == lsuPkg::clearing; // counter walks while clearing
	assign useClearData_o = state == lsuPkg::clearing; // zeros and counter index
	assign memReadEn_o = reqValid_i; // loads and storeRead
	assign memIndex_o = (state == lsuPkg::storeWrite) ? storeIndex : blockIndex_i;
	assign memWriteEn_o = state == lsuPkg::clearing || state == lsuPkg::storeWrite;
	assign storeDone_o = state == lsuPkg::storeWrite; // one cycle per store

endmodule

`default_nettype wire

/* rtl/lsuDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module lsuDecoder #(
	parameter int numBlocks = 128
) (
	input wire clock_i,
	input wire reset_i,
	input wire enable_i,
	input wire stall_i,
	input wire [1:0] functionalUnitCode_i,
	input wire [5:0] opCode_i,
	input wire [4:0] instructionFormat_i,
	input wire [63:0] operand1_i,
	input wire [63:0] operand2_i,
	input wire [4:0] reg1Address_i,
	input wire [4:0] reg2Address_i,
	input wire [15:0] imm_i,
	output lsuPkg::lsuReq_t req_o,
	output logic reqValid_o,
	output logic fault_o
);

	lsuPkg::lsuReq_t nextReq; // decoded fields of this issue
	logic known; // opcode is implemented here
	logic misaligned;
	logic outOfRange;
	logic accept; // issue is for us and we are free
	logic bad;

	assign accept = enable_i && !stall_i && functionalUnitCode_i == lsuPkg::ldStUnitCode
		&& instructionFormat_i == lsuPkg::formatD;

	always_comb begin
		known = 1'b1;
		nextReq.isStore = 1'b0;
		nextReq.size = lsuPkg::sizeWord;
		nextReq.isAlgebraic = 1'b0;
		nextReq.isUpdate = opCode_i[0]; // odd opcode means with update
		case (lsuPkg::opCode_t'(opCode_i))
			lsuPkg::opLwz, lsuPkg::opLwzu: nextReq.size = lsuPkg::sizeWord;
			lsuPkg::opLbz, lsuPkg::opLbzu: nextReq.size = lsuPkg::sizeByte;
			lsuPkg::opLhz, lsuPkg::opLhzu: nextReq.size = lsuPkg::sizeHalf;
			lsuPkg::opLha, lsuPkg::opLhau: begin
				nextReq.size = lsuPkg::sizeHalf;
				nextReq.isAlgebraic = 1'b1;
			end
			lsuPkg::opStw, lsuPkg::opStwu: nextReq.isStore = 1'b1; // word is the default size
			lsuPkg::opStb, lsuPkg::opStbu: begin
				nextReq.isStore = 1'b1;
				nextReq.size = lsuPkg::sizeByte;
			end
			lsuPkg::opSth, lsuPkg::opSthu: begin
				nextReq.isStore = 1'b1;
				nextReq.size = lsuPkg::sizeHalf;
			end
			lsuPkg::opLmw, lsuPkg::opStmw: known = 1'b0; // not implemented
			default: known = 1'b0; // not a D-form load/store
		endcase
		nextReq.effAddr = operand2_i + {{48{imm_i[15]}}, imm_i}; // ra + sign-extended d
		nextReq.blockIndex = nextReq.effAddr[10:4];
		nextReq.byteOffset = nextReq.effAddr[3:0];
		nextReq.storeVal = operand1_i; // rs for stores
		nextReq.rtAddr = reg1Address_i;
		nextReq.raAddr = reg2Address_i;
		case (nextReq.size)
			lsuPkg::sizeHalf: misaligned = nextReq.effAddr[0];
			lsuPkg::sizeWord: misaligned = |nextReq.effAddr[1:0];
			default: misaligned = 1'b0; // bytes are always aligned
		endcase
		outOfRange = nextReq.effAddr[63:4] >= 60'(numBlocks); // whole upper address
		bad = !known || misaligned || outOfRange;
	end

	always_ff @(posedge clock_i) begin
		if (accept && !bad)
			req_o <= nextReq; // held until the next good issue
		if (reset_i) begin
			reqValid_o <= 1'b0;
			fault_o <= 1'b0;
		end else begin
			reqValid_o <= accept && !bad; // one-cycle strobe
			fault_o <= accept && bad; // no other effect
		end
	end

endmodule

`default_nettype wire

/* rtl/lsuPkg.sv */
`default_nettype none

package lsuPkg;

	//////////////////////////////////////////////////
	// sizes and codes

	localparam int blockBits = 128; // one memory block
	localparam logic [1:0] ldStUnitCode = 2'd2; // dispatch id of this unit
	localparam logic [4:0] formatD = 5'd3; // D-form code from decode

	typedef logic [6:0] blockIndex_t; // block number within the memory

	// primary opcodes, odd ones are the update forms
	typedef enum logic [5:0] {
		opLwz = 6'd32,
		opLwzu = 6'd33,
		opLbz = 6'd34,
		opLbzu = 6'd35,
		opStw = 6'd36,
		opStwu = 6'd37,
		opStb = 6'd38,
		opStbu = 6'd39,
		opLhz = 6'd40,
		opLhzu = 6'd41,
		opLha = 6'd42, // halfword algebraic
		opLhau = 6'd43,
		opSth = 6'd44,
		opSthu = 6'd45,
		opLmw = 6'd46, // multiple forms, faulted
		opStmw = 6'd47
	} opCode_t;

	typedef enum logic [1:0] {sizeByte, sizeHalf, sizeWord} accessSize_t;

	typedef enum logic [1:0] {clearing, ready, storeRead, storeWrite} lsuState_t;

	//////////////////////////////////////////////////
	// bundles between the blocks

	typedef struct packed {
		logic isStore;
		accessSize_t size;
		logic isAlgebraic; // sign extend on load
		logic isUpdate; // effAddr goes back to ra
		blockIndex_t blockIndex;
		logic [3:0] byteOffset; // 0 is the top byte
		logic [63:0] effAddr;
		logic [63:0] storeVal;
		logic [4:0] rtAddr;
		logic [4:0] raAddr;
	} lsuReq_t;

	typedef struct packed {
		logic en;
		logic [4:0] addr;
		logic [63:0] value;
	} wbPort_t;

endpackage

`default_nettype wire
